// File: hdl/tcdm_reorder_pkg.sv
// tcdm reorder package: word, byte-enable and address widths shared by the subsystem
`default_nettype none

package tcdm_reorder_pkg;

  // memory word
  localparam int unsigned DATA_W = 32;

  // one enable per byte of a word
  localparam int unsigned BE_W = DATA_W / 8;

  // word address, wide enough for every bank together
  localparam int unsigned ADDR_W = 16;

  typedef logic [DATA_W-1:0] data_t;  // one channel word
  typedef logic [BE_W-1:0]   be_t;    // byte enables of one word
  typedef logic [ADDR_W-1:0] addr_t;  // word address, not byte address

endpackage : tcdm_reorder_pkg

`default_nettype wire

// File: hdl/tcdm_bank.sv
// tcdm bank: word-wide memory with byte-enabled writes and one-cycle reads
`default_nettype none

module tcdm_bank #(
  parameter int unsigned BANK_DEPTH = 64
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    stall_i,
  input  logic                    req_i,
  input  logic                    wen_i,    // low = write
  input  tcdm_reorder_pkg::addr_t add_i,    // local word address
  input  tcdm_reorder_pkg::be_t   be_i,
  input  tcdm_reorder_pkg::data_t wdata_i,
  output logic                    gnt_o,
  output tcdm_reorder_pkg::data_t rdata_o
);

  import tcdm_reorder_pkg::*;

  localparam int unsigned IDX_W  = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1;
  localparam int unsigned BYTE_W = DATA_W / BE_W;

  data_t            mem [BANK_DEPTH];
  logic [IDX_W-1:0] idx;
  logic             access;

  assign gnt_o  = ~stall_i;  // back-pressure only from outside
  assign access = req_i & gnt_o;
  assign idx    = add_i[IDX_W-1:0];

  always_ff @(posedge clk_i) begin
    if (access) begin
      if (!wen_i) begin
        for (int b = 0; b < BE_W; b++) begin
          if (be_i[b]) begin
            mem[idx][BYTE_W*b +: BYTE_W] <= wdata_i[BYTE_W*b +: BYTE_W];
          end
        end
      end else begin
        rdata_o <= mem[idx];  // available the next cycle
      end
    end
  end

  // top-level address split must stay inside the bank
  a_addr_in_range: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    req_i |-> (add_i < BANK_DEPTH)
  );

endmodule : tcdm_bank

`default_nettype wire

// File: hdl/lockstep_streamer.sv
// lockstep streamer: issues multi-word beats for one job and collects read responses
`default_nettype none

module lockstep_streamer #(
  parameter int unsigned NB_IN_CHAN  = 2,
  parameter int unsigned NB_OUT_CHAN = 4
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     clear_i,
  // job
  input  logic                                     start_i,
  input  logic                                     wen_i,     // low = write
  input  tcdm_reorder_pkg::addr_t                  base_i,
  input  logic [15:0]                              len_i,     // beats
  input  tcdm_reorder_pkg::be_t                    be_i,
  input  tcdm_reorder_pkg::data_t [NB_IN_CHAN-1:0] wdata_i,
  output logic                                     busy_o,
  output logic                                     beat_o,
  output logic                                     rvalid_o,
  output tcdm_reorder_pkg::data_t [NB_IN_CHAN-1:0] rdata_o,
  output logic                                     done_o,
  // channels towards the reorder block
  output logic [NB_IN_CHAN-1:0]                    ch_req_o,
  output logic [NB_IN_CHAN-1:0]                    ch_wen_o,
  output tcdm_reorder_pkg::addr_t [NB_IN_CHAN-1:0] ch_add_o,
  output tcdm_reorder_pkg::be_t [NB_IN_CHAN-1:0]   ch_be_o,
  output tcdm_reorder_pkg::data_t [NB_IN_CHAN-1:0] ch_wdata_o,
  output logic [$clog2(NB_OUT_CHAN)-1:0]           order_o,
  input  logic [NB_IN_CHAN-1:0]                    ch_gnt_i,  // only [0] is driven
  input  tcdm_reorder_pkg::data_t [NB_IN_CHAN-1:0] ch_rdata_i,
  input  logic [NB_IN_CHAN-1:0]                    ch_rvalid_i
);

  import tcdm_reorder_pkg::*;

  localparam int unsigned SEL_W = $clog2(NB_OUT_CHAN);

  logic        busy_q;
  logic [15:0] beats_left_q;
  logic        rsp_pend_q;    // fixed latency, so at most one beat in flight
  addr_t       addr_q;
  logic        wen_q;
  be_t         be_q;

  logic start_ok;
  logic req;
  logic grant;
  logic last_rsp;

  // zero-length jobs would never finish, so they are not accepted
  assign start_ok = start_i & ~busy_q & (len_i != '0);
  assign req      = busy_q & (beats_left_q != '0);
  assign grant    = req & ch_gnt_i[0];
  // last beat granted in the previous cycle
  assign last_rsp = busy_q & rsp_pend_q & (beats_left_q == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q       <= 1'b0;
      beats_left_q <= '0;
      rsp_pend_q   <= 1'b0;
    end else if (clear_i) begin
      busy_q       <= 1'b0;
      beats_left_q <= '0;
      rsp_pend_q   <= 1'b0;
    end else begin
      rsp_pend_q <= grant;
      if (start_ok) begin
        busy_q       <= 1'b1;
        beats_left_q <= len_i;
      end else begin
        if (last_rsp) begin
          busy_q <= 1'b0;
        end
        if (grant) begin
          beats_left_q <= beats_left_q - 16'd1;
        end
      end
    end
  end

  // job payload, only meaningful while busy
  always_ff @(posedge clk_i) begin
    if (start_ok) begin
      addr_q <= base_i;
      wen_q  <= wen_i;
      be_q   <= be_i;
    end else if (grant) begin
      addr_q <= addr_q + ADDR_W'(NB_IN_CHAN);  // next beat follows on
    end
  end

  // every channel moves in lockstep with channel 0
  assign ch_req_o   = {NB_IN_CHAN{req}};
  assign ch_wen_o   = {NB_IN_CHAN{wen_q}};
  assign ch_wdata_o = wdata_i;  // held by the source until beat_o

  for (genvar i = 0; i < NB_IN_CHAN; i++) begin : gen_chan
    assign ch_add_o[i] = addr_q + ADDR_W'(i);
    assign ch_be_o[i]  = be_q;
  end

  assign order_o = addr_q[SEL_W-1:0];  // bank of channel 0

  assign busy_o   = busy_q;
  assign beat_o   = grant;
  assign rvalid_o = ch_rvalid_i[0];
  assign rdata_o  = ch_rdata_i;
  assign done_o   = last_rsp;

  // a response must belong to a beat granted one cycle earlier
  a_rsp_expected: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ch_rvalid_i[0] |-> rsp_pend_q
  );

endmodule : lockstep_streamer

`default_nettype wire

// File: hdl/tcdm_reorder.sv
// tcdm reorder: rotates lockstep channels onto interleaved banks and routes responses back
`default_nettype none

module tcdm_reorder #(
  parameter int unsigned NB_IN_CHAN           = 2,
  parameter int unsigned NB_OUT_CHAN          = 4,
  parameter int unsigned FILTER_WRITE_R_VALID = 1
) (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      clear_i,
  input  logic [$clog2(NB_OUT_CHAN)-1:0]            order_i,
  // lockstep channels
  input  logic [NB_IN_CHAN-1:0]                     in_req_i,
  input  tcdm_reorder_pkg::addr_t [NB_IN_CHAN-1:0]  in_add_i,
  input  logic [NB_IN_CHAN-1:0]                     in_wen_i,
  input  tcdm_reorder_pkg::be_t [NB_IN_CHAN-1:0]    in_be_i,
  input  tcdm_reorder_pkg::data_t [NB_IN_CHAN-1:0]  in_wdata_i,
  output logic [NB_IN_CHAN-1:0]                     in_gnt_o,
  output tcdm_reorder_pkg::data_t [NB_IN_CHAN-1:0]  in_rdata_o,
  output logic [NB_IN_CHAN-1:0]                     in_rvalid_o,
  // banks
  output logic [NB_OUT_CHAN-1:0]                    out_req_o,
  output tcdm_reorder_pkg::addr_t [NB_OUT_CHAN-1:0] out_add_o,
  output logic [NB_OUT_CHAN-1:0]                    out_wen_o,
  output tcdm_reorder_pkg::be_t [NB_OUT_CHAN-1:0]   out_be_o,
  output tcdm_reorder_pkg::data_t [NB_OUT_CHAN-1:0] out_wdata_o,
  input  logic [NB_OUT_CHAN-1:0]                    out_gnt_i,
  input  tcdm_reorder_pkg::data_t [NB_OUT_CHAN-1:0] out_rdata_i
);

  localparam int unsigned SEL_W = $clog2(NB_OUT_CHAN);

  logic [NB_IN_CHAN-1:0][SEL_W-1:0]       sel_d;   // target bank per channel
  logic [NB_IN_CHAN-1:0][SEL_W-1:0]       sel_q;
  logic [NB_OUT_CHAN-1:0][NB_IN_CHAN-1:0] mat_req;
  logic                                   gnt;
  logic                                   rsp_req;
  logic                                   rvalid_q;

  for (genvar i = 0; i < NB_IN_CHAN; i++) begin : gen_sel
    assign sel_d[i] = order_i + SEL_W'(i);  // wraps modulo bank count
  end

  for (genvar o = 0; o < NB_OUT_CHAN; o++) begin : gen_out
    for (genvar i = 0; i < NB_IN_CHAN; i++) begin : gen_match
      assign mat_req[o][i] = in_req_i[0] & (sel_d[i] == SEL_W'(o));
    end

    // at most one channel hits a bank, so a plain OR merge is enough
    always_comb begin
      out_req_o[o]   = 1'b0;
      out_add_o[o]   = '0;
      out_wen_o[o]   = in_wen_i[0];
      out_be_o[o]    = '0;
      out_wdata_o[o] = '0;
      for (int i = 0; i < NB_IN_CHAN; i++) begin
        out_req_o[o]   |= mat_req[o][i];
        out_add_o[o]   |= mat_req[o][i] ? in_add_i[i] : '0;
        out_be_o[o]    |= mat_req[o][i] ? in_be_i[i] : '0;
        out_wdata_o[o] |= mat_req[o][i] ? in_wdata_i[i] : '0;
      end
    end

    a_one_chan_per_bank: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      $onehot0(mat_req[o])
    );
  end

  // shared grant, every requested bank has to accept
  assign gnt = &(~out_req_o | out_gnt_i);

  always_comb begin
    in_gnt_o    = '0;
    in_gnt_o[0] = gnt;
  end

  assign rsp_req = (FILTER_WRITE_R_VALID != 0) ? in_wen_i[0] : 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else if (clear_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= in_req_i[0] & gnt & rsp_req;
    end
  end

  // bank select of the granted beat, used for the response one cycle later
  always_ff @(posedge clk_i) begin
    if (in_req_i[0] & gnt) begin
      sel_q <= sel_d;
    end
  end

  for (genvar i = 0; i < NB_IN_CHAN; i++) begin : gen_rsp
    assign in_rdata_o[i]  = out_rdata_i[sel_q[i]];
    assign in_rvalid_o[i] = rvalid_q;  // fixed latency of one
  end

  // the streamer must drive all channels in lockstep
  a_lockstep: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    in_req_i[0] |-> (in_req_i == {NB_IN_CHAN{1'b1}}) &&
                    (in_wen_i == {NB_IN_CHAN{in_wen_i[0]}})
  );

endmodule : tcdm_reorder

`default_nettype wire

// File: hdl/tcdm_reorder_top.sv
// tcdm reorder top: streamer, reorder block and interleaved banks wired together
`default_nettype none

module tcdm_reorder_top #(
  parameter int unsigned NB_IN_CHAN           = 2,
  parameter int unsigned NB_OUT_CHAN          = 4,
  parameter int unsigned BANK_DEPTH           = 64,
  parameter int unsigned FILTER_WRITE_R_VALID = 1
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     clear_i,
  input  logic                                     start_i,
  input  logic                                     wen_i,
  input  tcdm_reorder_pkg::addr_t                  base_i,
  input  logic [15:0]                              len_i,
  input  tcdm_reorder_pkg::be_t                    be_i,
  input  tcdm_reorder_pkg::data_t [NB_IN_CHAN-1:0] wdata_i,
  input  logic [NB_OUT_CHAN-1:0]                   bank_stall_i,
  output logic                                     busy_o,
  output logic                                     beat_o,
  output logic                                     rvalid_o,
  output tcdm_reorder_pkg::data_t [NB_IN_CHAN-1:0] rdata_o,
  output logic                                     done_o
);

  import tcdm_reorder_pkg::*;

  localparam int unsigned SEL_W = $clog2(NB_OUT_CHAN);

  logic [NB_IN_CHAN-1:0]   ch_req;
  addr_t [NB_IN_CHAN-1:0]  ch_add;
  logic [NB_IN_CHAN-1:0]   ch_wen;
  be_t [NB_IN_CHAN-1:0]    ch_be;
  data_t [NB_IN_CHAN-1:0]  ch_wdata;
  logic [NB_IN_CHAN-1:0]   ch_gnt;
  data_t [NB_IN_CHAN-1:0]  ch_rdata;
  logic [NB_IN_CHAN-1:0]   ch_rvalid;
  logic [SEL_W-1:0]        order;

  logic [NB_OUT_CHAN-1:0]  bank_req;
  addr_t [NB_OUT_CHAN-1:0] bank_add;
  addr_t [NB_OUT_CHAN-1:0] bank_local_add;
  logic [NB_OUT_CHAN-1:0]  bank_wen;
  be_t [NB_OUT_CHAN-1:0]   bank_be;
  data_t [NB_OUT_CHAN-1:0] bank_wdata;
  logic [NB_OUT_CHAN-1:0]  bank_gnt;
  data_t [NB_OUT_CHAN-1:0] bank_rdata;

  lockstep_streamer #(
    .NB_IN_CHAN  (NB_IN_CHAN),
    .NB_OUT_CHAN (NB_OUT_CHAN)
  ) i_streamer (
    .clk_i, .rst_ni, .clear_i, .start_i, .wen_i, .base_i, .len_i, .be_i, .wdata_i,
    .busy_o, .beat_o, .rvalid_o, .rdata_o, .done_o,
    .ch_req_o    (ch_req),
    .ch_wen_o    (ch_wen),
    .ch_add_o    (ch_add),
    .ch_be_o     (ch_be),
    .ch_wdata_o  (ch_wdata),
    .order_o     (order),
    .ch_gnt_i    (ch_gnt),
    .ch_rdata_i  (ch_rdata),
    .ch_rvalid_i (ch_rvalid)
  );

  tcdm_reorder #(
    .NB_IN_CHAN           (NB_IN_CHAN),
    .NB_OUT_CHAN          (NB_OUT_CHAN),
    .FILTER_WRITE_R_VALID (FILTER_WRITE_R_VALID)
  ) i_reorder (
    .clk_i, .rst_ni, .clear_i,
    .order_i     (order),
    .in_req_i    (ch_req),
    .in_add_i    (ch_add),
    .in_wen_i    (ch_wen),
    .in_be_i     (ch_be),
    .in_wdata_i  (ch_wdata),
    .in_gnt_o    (ch_gnt),
    .in_rdata_o  (ch_rdata),
    .in_rvalid_o (ch_rvalid),
    .out_req_o   (bank_req),
    .out_add_o   (bank_add),
    .out_wen_o   (bank_wen),
    .out_be_o    (bank_be),
    .out_wdata_o (bank_wdata),
    .out_gnt_i   (bank_gnt),
    .out_rdata_i (bank_rdata)
  );

  for (genvar o = 0; o < NB_OUT_CHAN; o++) begin : gen_bank
    // low address bits pick the bank, the rest is the row
    assign bank_local_add[o] = bank_add[o] >> SEL_W;

    tcdm_bank #(
      .BANK_DEPTH (BANK_DEPTH)
    ) i_bank (
      .clk_i, .rst_ni,
      .stall_i (bank_stall_i[o]),
      .req_i   (bank_req[o]),
      .wen_i   (bank_wen[o]),
      .add_i   (bank_local_add[o]),
      .be_i    (bank_be[o]),
      .wdata_i (bank_wdata[o]),
      .gnt_o   (bank_gnt[o]),
      .rdata_o (bank_rdata[o])
    );
  end

endmodule : tcdm_reorder_top

`default_nettype wire

// File: bench/tcdm_reorder_tb.sv
// tcdm reorder testbench: write and read jobs against a reference memory, with stall checks
`default_nettype none

module tcdm_reorder_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import tcdm_reorder_pkg::*;

  localparam int NB_IN = 2;
  localparam int NB_OUT = 4;
  localparam int MEM_WORDS = NB_OUT * 64;
  localparam int TOTAL_BEATS = 76;  // sum of the job lengths below
  localparam int NB_JOBS = 14;
  localparam int CYCLE_LIMIT = TOTAL_BEATS * 16 + NB_JOBS * 8 + 200;  // 16 cycles per stalled beat
  localparam logic WRITE = 1'b0;
  localparam logic READ = 1'b1;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 clear_i;
  logic                 start_i;
  logic                 wen_i;
  addr_t                base_i;
  logic [15:0]          len_i;
  be_t                  be_i;
  data_t [NB_IN-1:0]    wdata_i;
  logic [NB_OUT-1:0]    bank_stall_i = '0;
  logic                 busy_o;
  logic                 beat_o;
  logic                 rvalid_o;
  data_t [NB_IN-1:0]    rdata_o;
  logic                 done_o;

  data_t       ref_mem [MEM_WORDS];    // reference memory by word address
  data_t       exp_words [MEM_WORDS];  // expected read words of the current job
  string       test_name;
  logic        job_wen;
  int          job_len;
  int          job_base;
  int          job_seq = 0;
  logic        stall_en;
  int unsigned cycles = 0;
  int          seen_seq = 0;
  int          cur_addr;
  int          beat_cnt;
  int          rsp_cnt;
  logic        active = 1'b0;
  logic        beat_prev = 1'b0;  // beat granted in the previous cycle

  tcdm_reorder_top #(
    .NB_IN_CHAN           (NB_IN),
    .NB_OUT_CHAN          (NB_OUT),
    .BANK_DEPTH           (64),
    .FILTER_WRITE_R_VALID (1)
  ) uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // byte merge rule of a bank write
  function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                        input be_t be);
    data_t res;
    res = old_word;
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) res[8*b +: 8] = new_word[8*b +: 8];
    end
    return res;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic check_idle(input string where);
    @(negedge clk_i);
    check_value({where, " busy/beat/rvalid/done"}, 0, {28'b0, busy_o, beat_o, rvalid_o, done_o});
  endtask

  // one job; poke raises start_i again while busy, with a longer length
  task automatic run_job(input string name, input logic wen, input int base, input int len,
                         input be_t be, input bit poke);
    data_t wq[$];
    data_t w;
    for (int k = 0; k < len * NB_IN; k++) begin
      if (wen == WRITE) begin
        w = $urandom();
        wq.push_back(w);
        ref_mem[base + k] = merge_bytes(ref_mem[base + k], w, be);
      end else begin
        exp_words[k] = ref_mem[base + k];
      end
    end
    @(posedge clk_i);
    test_name = name;
    job_wen = wen;
    job_len = len;
    job_base = base;
    job_seq++;
    start_i <= 1'b1;
    wen_i <= wen;
    base_i <= addr_t'(base);
    len_i <= 16'(len);
    be_i <= be;
    for (int i = 0; i < NB_IN; i++) wdata_i[i] <= (wen == WRITE) ? wq[i] : '0;
    @(posedge clk_i);
    start_i <= 1'b0;
    for (int b = 0; b < len; b++) begin
      do @(negedge clk_i); while (!beat_o);
      @(posedge clk_i);  // beat taken at this edge
      start_i <= poke && (b == 0);
      if (poke) len_i <= 16'(len + 7);
      if (wen == WRITE && b + 1 < len) begin
        for (int i = 0; i < NB_IN; i++) wdata_i[i] <= wq[(b + 1) * NB_IN + i];
      end
    end
    do @(negedge clk_i); while (!done_o);
    @(negedge clk_i);
    check_value({name, " busy_o after done"}, 0, 32'(busy_o));
  endtask

  always @(posedge clk_i) begin
    bank_stall_i <= stall_en ? NB_OUT'($urandom()) : '0;
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) fail_run("timeout, the jobs did not finish within the cycle limit");
  end

  // compares every beat, response and done pulse with the reference
  always @(negedge clk_i) begin
    if (job_seq != seen_seq) begin
      seen_seq = job_seq;
      cur_addr = job_base;
      beat_cnt = 0;
      rsp_cnt = 0;
      beat_prev = 1'b0;
      active = 1'b1;
    end
    if ((beat_o || rvalid_o || done_o) && !active) fail_run("DUT activity outside a running job");
    if (active) begin
      // response and done come one cycle after a grant
      check_value({test_name, " done_o timing"}, 32'(beat_prev && beat_cnt == job_len),
                  32'(done_o));
      if (job_wen == READ) begin
        check_value({test_name, " rvalid_o timing"}, 32'(beat_prev), 32'(rvalid_o));
      end
    end
    beat_prev = beat_o;
    if (beat_o) begin
      for (int i = 0; i < NB_IN; i++) begin
        if (bank_stall_i[(cur_addr + i) % NB_OUT]) begin
          fail_run($sformatf("beat granted while bank %0d is stalled", (cur_addr + i) % NB_OUT));
        end
      end
      cur_addr += NB_IN;
      beat_cnt++;
    end
    if (rvalid_o) begin
      if (job_wen == WRITE) fail_run("rvalid_o raised during a write job");
      for (int i = 0; i < NB_IN; i++) begin
        check_value(test_name, exp_words[rsp_cnt * NB_IN + i], rdata_o[i]);
      end
      rsp_cnt++;
    end
    if (done_o) begin
      check_value({test_name, " beat count"}, job_len, beat_cnt);
      if (job_wen == READ) check_value({test_name, " response count"}, job_len, rsp_cnt);
      active = 1'b0;
    end
  end

  initial begin
    void'($urandom(32'hc034_1aeb));
    rst_ni = 1'b0;
    clear_i = 1'b0;
    start_i = 1'b0;
    wen_i = 1'b0;
    base_i = '0;
    len_i = '0;
    be_i = '0;
    wdata_i = '0;
    stall_en = 1'b0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    check_idle("after reset");
    @(posedge clk_i);
    clear_i <= 1'b1;
    @(posedge clk_i);
    clear_i <= 1'b0;
    check_idle("after clear");

    run_job("aligned write", WRITE, 0, 8, 4'hf, 1'b0);
    run_job("aligned read", READ, 0, 8, 4'hf, 1'b0);
    for (int off = 1; off <= 3; off++) begin  // rotations 1 to 3
      run_job("unaligned write", WRITE, off, 3, 4'hf, 1'b0);
      run_job("unaligned read", READ, off - 1, 5, 4'hf, 1'b0);
    end
    run_job("full read back", READ, 0, 8, 4'hf, 1'b0);
    run_job("partial write", WRITE, 5, 4, 4'b0101, 1'b0);
    run_job("partial read", READ, 4, 6, 4'hf, 1'b0);

    stall_en = 1'b1;
    run_job("stalled write", WRITE, 1, 6, 4'hf, 1'b0);
    run_job("stalled read", READ, 0, 8, 4'hf, 1'b0);
    stall_en = 1'b0;
    run_job("start while busy", READ, 0, 4, 4'hf, 1'b1);

    $display("test passed");
    $finish;
  end

endmodule : tcdm_reorder_tb

`default_nettype wire

// File: tcdm_reorder_top.f
hdl/tcdm_reorder_pkg.sv
hdl/tcdm_bank.sv
hdl/lockstep_streamer.sv
hdl/tcdm_reorder.sv
hdl/tcdm_reorder_top.sv
bench/tcdm_reorder_tb.sv

// File: run.sh
#!/bin/sh
# build and run the tcdm reorder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tcdm_reorder_tb \
  -f tcdm_reorder_top.f --Mdir build -o tcdm_reorder_tb

./build/tcdm_reorder_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log; then
  echo "simulation FAILED"
  exit 1
fi
echo "simulation finished without errors"
